//--- common/bridge_pkg.sv
/*
 * bridge package
 * host bridge address map, ROM window layout and loader FSM states
 */

package bridge_pkg;

    //////////////////////////////////////////////////////////////////////
    // bridge bus
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    // download control and status register
    localparam bridge_addr_t ctrl_addr = 32'hF800_0000;

    // rom window is 0x10xxxxxx
    localparam logic [7:0] rom_base_top = 8'h10;

    //////////////////////////////////////////////////////////////////////
    // rom regions, offsets inside the rom window
    //////////////////////////////////////////////////////////////////////

    typedef logic [24:0] load_addr_t;

    // main program at the bottom
    localparam int main_rom_bytes = 32768;

    // sound program, hi bound exclusive
    localparam load_addr_t snd_rom_lo = 25'h000_E000;
    localparam load_addr_t snd_rom_hi = 25'h000_F000;
    localparam int snd_rom_bytes = 4096;

    // wave samples fill the last page
    localparam load_addr_t wav_rom_lo = 25'h000_FF00;
    localparam int wav_rom_bytes = 256;

    typedef logic [14:0] main_addr_t;
    typedef logic [11:0] snd_addr_t;
    typedef logic [7:0]  wav_addr_t;
    typedef logic [7:0]  rom_byte_t;

    // loader: waiting for a word, or emitting its bytes
    typedef enum logic {
        idle  = 1'b0,
        shift = 1'b1
    } loader_state_e;

endpackage

//--- common/video_pkg.sv
/*
 * video and controller package
 * colour channel widths, controller key bit positions, sync depth
 */

package video_pkg;

    // 4 bits per channel from the core, 8 per channel to the scaler
    typedef logic [3:0]  chan_t;
    typedef logic [23:0] rgb_t;

    // controller key bitmap from the host
    typedef logic [15:0] key_t;

    // bit positions in the key bitmap, only the ones the game uses
    typedef enum logic [3:0] {
        up     = 4'd0,
        down   = 4'd1,
        left   = 4'd2,
        right  = 4'd3,
        face_a = 4'd4,
        select = 4'd14,
        start  = 4'd15
    } key_bit_e;

    // flops in the key synchronizer
    localparam int sync_stages = 3;

endpackage

//--- logic/bridge_regs.sv
/*
 * bridge registers
 * download control flag, registered game reset, bridge read mux
 */
`timescale 1ns/1ps

module bridge_regs (
    input  logic                     clk_74a,
    input  logic                     rst_n,
    input  bridge_pkg::bridge_addr_t bridge_addr,
    input  logic                     bridge_wr,
    input  bridge_pkg::bridge_data_t bridge_wr_data,
    input  logic                     bridge_rd,
    output bridge_pkg::bridge_data_t bridge_rd_data,
    output logic                     downloading,
    output logic                     game_rst_n
);
    import bridge_pkg::*;

    // download flag, bit 0 of the control register
    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            downloading <= 1'b0;
        end else if (bridge_wr && (bridge_addr == ctrl_addr)) begin
            downloading <= bridge_wr_data[0];
        end
    end

    // game held in reset during a download, one cycle behind the flag
    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            game_rst_n <= 1'b0;
        end else begin
            game_rst_n <= !downloading;
        end
    end

    // read mux, only the control register answers
    assign bridge_rd_data = (bridge_addr == ctrl_addr) ? {31'd0, downloading} : '0;

    // single-cycle strobes, never both at once
    a_rd_wr_exclusive: assert property (
        @(posedge clk_74a) disable iff (!rst_n) !(bridge_rd && bridge_wr)
    ) else $error("bridge read and write strobes high together");

endmodule

//--- loader/rom_loader.sv
/*
 * rom loader
 * takes 32-bit bridge writes into the rom window during a download
 * and replays them as four byte writes, high byte first
 */
`timescale 1ns/1ps

module rom_loader (
    input  logic                     clk_74a,
    input  logic                     rst_n,
    input  bridge_pkg::bridge_addr_t bridge_addr,
    input  logic                     bridge_wr,
    input  bridge_pkg::bridge_data_t bridge_wr_data,
    input  logic                     downloading,
    output logic                     load_wr,
    output bridge_pkg::load_addr_t   load_addr,
    output bridge_pkg::rom_byte_t    load_data
);
    import bridge_pkg::*;

    loader_state_e state;
    // word being emitted, shifted left one byte per cycle
    bridge_data_t  word_q;
    // word-aligned part of the byte offset
    logic [22:0]   word_addr;
    // which byte of the word is on the output
    logic [1:0]    byte_cnt;
    logic          win_wr;
    logic          accept;

    // any write into 0x10xxxxxx
    assign win_wr = bridge_wr && (bridge_addr[31:24] == rom_base_top);
    // only taken while idle and downloading
    assign accept = (state == idle) && win_wr && downloading;

    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            state    <= idle;
            byte_cnt <= 2'd0;
        end else begin
            case (state)
                idle: begin
                    byte_cnt <= 2'd0;
                    if (accept) begin
                        state <= shift;
                    end
                end
                shift: begin
                    byte_cnt <= byte_cnt + 2'd1;
                    // last byte out, back to waiting
                    if (byte_cnt == 2'd3) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // word and address, loaded on accept
    always_ff @(posedge clk_74a) begin
        if (accept) begin
            word_q    <= bridge_wr_data;
            word_addr <= bridge_addr[24:2];
        end else if (state == shift) begin
            word_q <= {word_q[23:0], 8'h00};
        end
    end

    // big endian: bits 31:24 land at the lowest offset
    assign load_wr   = (state == shift);
    assign load_addr = {word_addr, byte_cnt};
    assign load_data = word_q[31:24];

    // host must leave 5 cycles between rom words
    a_no_word_while_shifting: assert property (
        @(posedge clk_74a) disable iff (!rst_n)
        (state == shift) |-> !win_wr
    ) else $error("rom window write while loader is shifting");

endmodule

//--- loader/rom_store.sv
/*
 * rom store
 * main, sound and wave rom regions, written from the loader byte
 * stream and read by the game core through registered ports
 */
`timescale 1ns/1ps

module rom_store (
    input  logic                   clk_74a,
    input  logic                   load_wr,
    input  bridge_pkg::load_addr_t load_addr,
    input  bridge_pkg::rom_byte_t  load_data,
    input  bridge_pkg::main_addr_t main_rom_a,
    input  bridge_pkg::snd_addr_t  snd_rom_a,
    input  bridge_pkg::wav_addr_t  wav_rom_a,
    output bridge_pkg::rom_byte_t  main_rom_do,
    output bridge_pkg::rom_byte_t  snd_rom_do,
    output bridge_pkg::rom_byte_t  wav_rom_do
);
    import bridge_pkg::*;

    rom_byte_t  main_mem [main_rom_bytes];
    rom_byte_t  snd_mem  [snd_rom_bytes];
    rom_byte_t  wav_mem  [wav_rom_bytes];

    logic       main_we;
    logic       snd_we;
    logic       wav_we;
    // offsets relative to each region start
    load_addr_t snd_off;
    load_addr_t wav_off;

    //////////////////////////////////////////////////////////////////////
    // download side decode
    //////////////////////////////////////////////////////////////////////

    assign snd_off = load_addr - snd_rom_lo;
    assign wav_off = load_addr - wav_rom_lo;

    // anything outside the three regions falls through unwritten
    assign main_we = load_wr && (load_addr < main_rom_bytes);
    assign snd_we  = load_wr && (load_addr >= snd_rom_lo) && (load_addr < snd_rom_hi);
    assign wav_we  = load_wr && (load_addr >= wav_rom_lo)
                     && (load_addr < wav_rom_lo + wav_rom_bytes);

    //////////////////////////////////////////////////////////////////////
    // byte write and registered game read per region
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (main_we) begin
            main_mem[load_addr[14:0]] <= load_data;
        end
        main_rom_do <= main_mem[main_rom_a];
    end

    always_ff @(posedge clk_74a) begin
        if (snd_we) begin
            snd_mem[snd_off[11:0]] <= load_data;
        end
        snd_rom_do <= snd_mem[snd_rom_a];
    end

    always_ff @(posedge clk_74a) begin
        if (wav_we) begin
            wav_mem[wav_off[7:0]] <= load_data;
        end
        wav_rom_do <= wav_mem[wav_rom_a];
    end

endmodule

//--- logic/input_sync.sv
/*
 * input sync
 * synchronizes both controller key bitmaps and maps them onto
 * the active-low game joystick, fire, start and coin lines
 */
`timescale 1ns/1ps

module input_sync (
    input  logic            clk_74a,
    input  logic            rst_n,
    input  video_pkg::key_t cont1_key,
    input  video_pkg::key_t cont2_key,
    output logic            up1_n,
    output logic            down1_n,
    output logic            left1_n,
    output logic            right1_n,
    output logic            fire1_n,
    output logic            up2_n,
    output logic            down2_n,
    output logic            left2_n,
    output logic            right2_n,
    output logic            fire2_n,
    output logic            start1_n,
    output logic            start2_n,
    output logic            coin_n
);
    import video_pkg::*;

    // synchronizer chains, stage 0 samples the host bitmap
    key_t k1_q [sync_stages];
    key_t k2_q [sync_stages];
    key_t k1;
    key_t k2;

    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            // nothing pressed
            for (int i = 0; i < sync_stages; i++) begin
                k1_q[i] <= '0;
                k2_q[i] <= '0;
            end
        end else begin
            k1_q[0] <= cont1_key;
            k2_q[0] <= cont2_key;
            for (int i = 1; i < sync_stages; i++) begin
                k1_q[i] <= k1_q[i-1];
                k2_q[i] <= k2_q[i-1];
            end
        end
    end

    assign k1 = k1_q[sync_stages-1];
    assign k2 = k2_q[sync_stages-1];

    // player 1
    assign up1_n    = ~k1[up];
    assign down1_n  = ~k1[down];
    assign left1_n  = ~k1[left];
    assign right1_n = ~k1[right];
    assign fire1_n  = ~k1[face_a];
    // player 2
    assign up2_n    = ~k2[up];
    assign down2_n  = ~k2[down];
    assign left2_n  = ~k2[left];
    assign right2_n = ~k2[right];
    assign fire2_n  = ~k2[face_a];

    assign start1_n = ~k1[start];
    assign start2_n = ~k2[start];
    // select on either pad drops a coin
    assign coin_n   = ~(k1[select] | k2[select]);

endmodule

//--- logic/video_out.sv
/*
 * video out
 * 12-bit core colour to 24-bit rgb with data enable,
 * active-low syncs to single-cycle sync pulses
 */
`timescale 1ns/1ps

module video_out (
    input  logic             clk_74a,
    input  logic             rst_n,
    input  video_pkg::chan_t core_r,
    input  video_pkg::chan_t core_g,
    input  video_pkg::chan_t core_b,
    input  logic             hblank,
    input  logic             vblank,
    input  logic             hs_n,
    input  logic             vs_n,
    output video_pkg::rgb_t  video_rgb,
    output logic             video_de,
    output logic             video_hs,
    output logic             video_vs
);
    // previous sync levels for falling edge detect
    logic hs_n_q;
    logic vs_n_q;
    logic active;

    assign active = !(hblank || vblank);

    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            // syncs idle high
            hs_n_q   <= 1'b1;
            vs_n_q   <= 1'b1;
            video_de <= 1'b0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
        end else begin
            hs_n_q   <= hs_n;
            vs_n_q   <= vs_n;
            video_de <= active;
            // high to low on the sync gives one pulse
            video_hs <= hs_n_q && !hs_n;
            video_vs <= vs_n_q && !vs_n;
        end
    end

    // nibble doubled so 0xF maps to 0xFF
    // last colour held during blanking
    always_ff @(posedge clk_74a) begin
        if (active) begin
            video_rgb <= {{2{core_r}}, {2{core_g}}, {2{core_b}}};
        end
    end

endmodule

//--- logic/core_top.sv
/*
 * core top
 * host glue for the arcade core: bridge registers, rom download,
 * game rom storage, controller inputs and video formatting
 */
`timescale 1ns/1ps

module core_top (
    input  logic                     clk_74a,
    input  logic                     rst_n,
    input  bridge_pkg::bridge_addr_t bridge_addr,
    input  logic                     bridge_wr,
    input  bridge_pkg::bridge_data_t bridge_wr_data,
    input  logic                     bridge_rd,
    output bridge_pkg::bridge_data_t bridge_rd_data,
    input  bridge_pkg::main_addr_t   main_rom_a,
    input  bridge_pkg::snd_addr_t    snd_rom_a,
    input  bridge_pkg::wav_addr_t    wav_rom_a,
    output bridge_pkg::rom_byte_t    main_rom_do,
    output bridge_pkg::rom_byte_t    snd_rom_do,
    output bridge_pkg::rom_byte_t    wav_rom_do,
    output logic                     game_rst_n,
    input  video_pkg::key_t          cont1_key,
    input  video_pkg::key_t          cont2_key,
    output logic                     up1_n,
    output logic                     down1_n,
    output logic                     left1_n,
    output logic                     right1_n,
    output logic                     fire1_n,
    output logic                     up2_n,
    output logic                     down2_n,
    output logic                     left2_n,
    output logic                     right2_n,
    output logic                     fire2_n,
    output logic                     start1_n,
    output logic                     start2_n,
    output logic                     coin_n,
    input  video_pkg::chan_t         core_r,
    input  video_pkg::chan_t         core_g,
    input  video_pkg::chan_t         core_b,
    input  logic                     hblank,
    input  logic                     vblank,
    input  logic                     hs_n,
    input  logic                     vs_n,
    output video_pkg::rgb_t          video_rgb,
    output logic                     video_de,
    output logic                     video_hs,
    output logic                     video_vs
);
    import bridge_pkg::*;

    // download flag from the control register
    logic       downloading;
    // byte stream from loader to rom store
    logic       load_wr;
    load_addr_t load_addr;
    rom_byte_t  load_data;

    //////////////////////////////////////////////////////////////////////
    // host side
    //////////////////////////////////////////////////////////////////////

    bridge_regs u_bridge_regs (
        .clk_74a        (clk_74a),
        .rst_n          (rst_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd      (bridge_rd),
        .bridge_rd_data (bridge_rd_data),
        .downloading    (downloading),
        .game_rst_n     (game_rst_n)
    );

    rom_loader u_rom_loader (
        .clk_74a        (clk_74a),
        .rst_n          (rst_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .downloading    (downloading),
        .load_wr        (load_wr),
        .load_addr      (load_addr),
        .load_data      (load_data)
    );

    //////////////////////////////////////////////////////////////////////
    // game side
    //////////////////////////////////////////////////////////////////////

    rom_store u_rom_store (
        .clk_74a     (clk_74a),
        .load_wr     (load_wr),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .main_rom_a  (main_rom_a),
        .snd_rom_a   (snd_rom_a),
        .wav_rom_a   (wav_rom_a),
        .main_rom_do (main_rom_do),
        .snd_rom_do  (snd_rom_do),
        .wav_rom_do  (wav_rom_do)
    );

    input_sync u_input_sync (
        .clk_74a   (clk_74a),
        .rst_n     (rst_n),
        .cont1_key (cont1_key),
        .cont2_key (cont2_key),
        .up1_n     (up1_n),
        .down1_n   (down1_n),
        .left1_n   (left1_n),
        .right1_n  (right1_n),
        .fire1_n   (fire1_n),
        .up2_n     (up2_n),
        .down2_n   (down2_n),
        .left2_n   (left2_n),
        .right2_n  (right2_n),
        .fire2_n   (fire2_n),
        .start1_n  (start1_n),
        .start2_n  (start2_n),
        .coin_n    (coin_n)
    );

    video_out u_video_out (
        .clk_74a   (clk_74a),
        .rst_n     (rst_n),
        .core_r    (core_r),
        .core_g    (core_g),
        .core_b    (core_b),
        .hblank    (hblank),
        .vblank    (vblank),
        .hs_n      (hs_n),
        .vs_n      (vs_n),
        .video_rgb (video_rgb),
        .video_de  (video_de),
        .video_hs  (video_hs),
        .video_vs  (video_vs)
    );

endmodule

//--- sim/tb_clock.sv
/*
 * testbench clock and reset
 * 100 ns clk_74a, rst_n held low for the first 16 cycles
 */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_74a,
    output logic rst_n
);

    // 50 ns half period
    initial begin
        clk_74a = 1'b0;
        forever #50 clk_74a = ~clk_74a;
    end

    // release on a rising edge after 16 cycles
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk_74a);
        rst_n <= 1'b1;
    end

endmodule

//--- sim/tb_core.sv
/*
 * core top testbench
 * bridge control register, rom download and game readback,
 * controller mapping and video formatting against reference models
 */
`timescale 1ns/1ps

module tb_core;
    import bridge_pkg::*;

    // which dut output the comparing process looks at
    localparam int sel_rd   = 0;
    localparam int sel_main = 1;
    localparam int sel_snd  = 2;
    localparam int sel_wav  = 3;
    localparam int sel_pads = 4;
    localparam int sel_vid  = 5;
    localparam int sel_de   = 6;
    localparam int sel_sync = 7;
    localparam int sel_grst = 8;

    logic         clk_74a;
    logic         rst_n;
    bridge_addr_t bridge_addr;
    logic         bridge_wr;
    bridge_data_t bridge_wr_data;
    logic         bridge_rd;
    bridge_data_t bridge_rd_data;
    main_addr_t   main_rom_a;
    snd_addr_t    snd_rom_a;
    wav_addr_t    wav_rom_a;
    rom_byte_t    main_rom_do;
    rom_byte_t    snd_rom_do;
    rom_byte_t    wav_rom_do;
    logic         game_rst_n;
    logic [15:0]  cont1_key;
    logic [15:0]  cont2_key;
    logic         up1_n;
    logic         down1_n;
    logic         left1_n;
    logic         right1_n;
    logic         fire1_n;
    logic         up2_n;
    logic         down2_n;
    logic         left2_n;
    logic         right2_n;
    logic         fire2_n;
    logic         start1_n;
    logic         start2_n;
    logic         coin_n;
    logic [3:0]   core_r;
    logic [3:0]   core_g;
    logic [3:0]   core_b;
    logic         hblank;
    logic         vblank;
    logic         hs_n;
    logic         vs_n;
    logic [23:0]  video_rgb;
    logic         video_de;
    logic         video_hs;
    logic         video_vs;

    int           seed = 39274;
    int           n_checks = 0;
    // pending comparison, picked up on the next falling edge
    logic         cmp_valid;
    int           cmp_sel;
    logic [31:0]  cmp_exp;
    string        cmp_name;
    // reference copy of every rom word written, keyed by window offset
    logic [31:0]  words [int];
    int           offs [$];

    tb_clock u_clock (
        .clk_74a (clk_74a),
        .rst_n   (rst_n)
    );

    core_top DUT (.*);

    //////////////////////////////////////////////////////////////////////
    // reference models
    //////////////////////////////////////////////////////////////////////

    function automatic int region_base(input int region);
        case (region)
            0:       return 0;
            1:       return int'(snd_rom_lo);
            default: return int'(wav_rom_lo);
        endcase
    endfunction

    // region holding a window offset, -1 when it falls outside all three
    function automatic int region_of(input int win);
        if (win < main_rom_bytes) return 0;
        if (win >= int'(snd_rom_lo) && win < int'(snd_rom_hi)) return 1;
        if (win >= int'(wav_rom_lo) && win < int'(wav_rom_lo) + wav_rom_bytes) return 2;
        return -1;
    endfunction

    function automatic logic [7:0] ref_byte(input int region, input int roff);
        int          win;
        logic [31:0] w;
        win = region_base(region) + roff;
        w   = words.exists(win - win % 4) ? words[win - win % 4] : 32'h0;
        // high byte sits at the lowest offset
        w = w >> (8 * (3 - win % 4));
        return w[7:0];
    endfunction

    // key bits: up 0, down 1, left 2, right 3, a 4, select 14, start 15
    function automatic logic [12:0] ref_pads(input logic [15:0] k1, input logic [15:0] k2);
        return ~{k1[0], k1[1], k1[2], k1[3], k1[4],
                 k2[0], k2[1], k2[2], k2[3], k2[4],
                 k1[15], k2[15], k1[14] | k2[14]};
    endfunction

    function automatic logic [31:0] pick_actual(input int sel);
        case (sel)
            sel_rd:   return bridge_rd_data;
            sel_main: return {24'd0, main_rom_do};
            sel_snd:  return {24'd0, snd_rom_do};
            sel_wav:  return {24'd0, wav_rom_do};
            sel_pads: return {19'd0, up1_n, down1_n, left1_n, right1_n, fire1_n,
                              up2_n, down2_n, left2_n, right2_n, fire2_n,
                              start1_n, start2_n, coin_n};
            sel_vid:  return {7'd0, video_de, video_rgb};
            sel_de:   return {31'd0, video_de};
            sel_sync: return {30'd0, video_hs, video_vs};
            sel_grst: return {31'd0, game_rst_n};
            default:  return 32'hDEAD_BEEF;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // comparing process, outputs are settled on the falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk_74a) begin : compare
        logic [31:0] act;
        if (cmp_valid) begin
            act = pick_actual(cmp_sel);
            n_checks++;
            assert (act === cmp_exp) else begin
                $display("ERR %s expected %08h actual %08h", cmp_name, cmp_exp, act);
                $display("Test failed");
                $fatal(1, "mismatch in %s", cmp_name);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bus and check helpers
    //////////////////////////////////////////////////////////////////////

    // strobes drop unless the caller raises them again this edge
    task automatic next_cycle;
        @(posedge clk_74a);
        bridge_wr <= 1'b0;
        bridge_rd <= 1'b0;
        cmp_valid = 1'b0;
    endtask

    task automatic expect_now(input string name, input int sel, input logic [31:0] exp);
        cmp_valid = 1'b1;
        cmp_name  = name;
        cmp_sel   = sel;
        cmp_exp   = exp;
    endtask

    task automatic wait_reset_release(input int limit);
        int n;
        n = 0;
        while (rst_n !== 1'b1) begin
            if (n == limit) begin
                $display("reset was not released within %0d cycles", limit);
                $display("Test failed");
                $fatal(1, "reset timeout");
            end
            @(negedge clk_74a);
            n++;
        end
    endtask

    task automatic wait_game_rst(input logic level, input int limit);
        int n;
        n = 0;
        while (game_rst_n !== level) begin
            if (n == limit) begin
                $display("game reset did not go to %0b within %0d cycles", level, limit);
                $display("Test failed");
                $fatal(1, "game reset timeout");
            end
            @(negedge clk_74a);
            n++;
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        next_cycle;
        bridge_addr    <= addr;
        bridge_wr      <= 1'b1;
        bridge_wr_data <= data;
    endtask

    task automatic bus_read_check(input logic [31:0] addr, input logic [31:0] exp,
                                  input string name);
        next_cycle;
        bridge_addr <= addr;
        bridge_rd   <= 1'b1;
        expect_now(name, sel_rd, exp);
    endtask

    // one word into the rom window, then room for its four bytes
    task automatic write_rom_word(input int off, input logic [31:0] data, input bit store);
        bus_write({rom_base_top, 24'(off)}, data);
        if (store) begin
            words[off] = data;
        end
        repeat (4) next_cycle;
    endtask

    // four pipelined byte reads, data checked one cycle behind its address
    task automatic read_word(input int region, input int roff, input string name);
        for (int b = 0; b < 5; b++) begin
            next_cycle;
            if (b < 4) begin
                case (region)
                    0:       main_rom_a <= main_addr_t'(roff + b);
                    1:       snd_rom_a  <= snd_addr_t'(roff + b);
                    default: wav_rom_a  <= wav_addr_t'(roff + b);
                endcase
            end
            if (b > 0) begin
                expect_now(name, sel_main + region, {24'd0, ref_byte(region, roff + b - 1)});
            end
        end
    endtask

    // falling sync edge, one pulse a cycle later, then quiet
    task automatic sync_edge(input logic hs_fall, input logic vs_fall, input string name);
        next_cycle;
        hs_n <= !hs_fall;
        vs_n <= !vs_fall;
        expect_now(name, sel_sync, 32'd0);
        next_cycle;
        expect_now(name, sel_sync, {30'd0, hs_fall, vs_fall});
        next_cycle;
        hs_n <= 1'b1;
        vs_n <= 1'b1;
        expect_now(name, sel_sync, 32'd0);
        next_cycle;
        expect_now(name, sel_sync, 32'd0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [15:0] k1;
        logic [15:0] k2;
        logic [3:0]  r;
        logic [3:0]  g;
        logic [3:0]  b;
        int          rg;

        bridge_addr    = '0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        bridge_rd      = 1'b0;
        main_rom_a     = '0;
        snd_rom_a      = '0;
        wav_rom_a      = '0;
        cont1_key      = '0;
        cont2_key      = '0;
        core_r         = '0;
        core_g         = '0;
        core_b         = '0;
        hblank         = 1'b1;
        vblank         = 1'b1;
        hs_n           = 1'b1;
        vs_n           = 1'b1;
        cmp_valid      = 1'b0;

        wait_reset_release(40);

        // reset state and the control register
        wait_game_rst(1'b1, 4);
        bus_read_check(ctrl_addr, 32'd0, "ctrl_after_reset");
        next_cycle;
        expect_now("game_rst_after_reset", sel_grst, 32'd1);
        bus_write(ctrl_addr, 32'd1);
        next_cycle;
        wait_game_rst(1'b0, 2);
        bus_read_check(ctrl_addr, 32'd1, "ctrl_download_set");
        bus_read_check(32'h1000_0000, 32'd0, "read_rom_window");
        bus_read_check(ctrl_addr + 32'd4, 32'd0, "read_next_to_ctrl");
        bus_read_check($random(seed) & 32'h0FFF_FFFC, 32'd0, "read_random_addr");

        // download into all regions, plus offsets that must be dropped
        offs = '{'h0000, 'h0010, 'h7FFC, 'hE000, 'hEFFC, 'hFF00, 'hFF80, 'hFFFC,
                 'h8000, 'hF000, 'h1_8010, 'h1_E000};
        offs.push_back($random(seed) & 'h7FFC);
        offs.push_back('hE000 + ($random(seed) & 'hFFC));
        foreach (offs[i]) begin
            write_rom_word(offs[i], $random(seed), 1'b1);
        end
        repeat (2) next_cycle;
        foreach (offs[i]) begin
            rg = region_of(offs[i]);
            if (rg >= 0) begin
                read_word(rg, offs[i] - region_base(rg), "rom_load");
            end
        end

        // flag cleared, window writes ignored
        bus_write(ctrl_addr, 32'd0);
        next_cycle;
        wait_game_rst(1'b1, 2);
        bus_read_check(ctrl_addr, 32'd0, "ctrl_download_clear");
        write_rom_word('h0010, $random(seed), 1'b0);
        write_rom_word('hE000, $random(seed), 1'b0);
        write_rom_word('hFF80, $random(seed), 1'b0);
        repeat (2) next_cycle;
        read_word(0, 'h10, "idle_write_main");
        read_word(1, 'h00, "idle_write_snd");
        read_word(2, 'h80, "idle_write_wav");

        // controllers, three sync stages
        for (int i = 0; i < 12; i++) begin
            k1 = 16'($random(seed));
            k2 = 16'($random(seed));
            next_cycle;
            cont1_key <= k1;
            cont2_key <= k2;
            repeat (3) next_cycle;
            expect_now("pad_mapping", sel_pads, {19'd0, ref_pads(k1, k2)});
        end

        // active video, nibble doubled
        for (int i = 0; i < 8; i++) begin
            r = 4'($random(seed));
            g = 4'($random(seed));
            b = 4'($random(seed));
            next_cycle;
            core_r <= r;
            core_g <= g;
            core_b <= b;
            hblank <= 1'b0;
            vblank <= 1'b0;
            next_cycle;
            expect_now("video_active", sel_vid, {7'd0, 1'b1, r, r, g, g, b, b});
        end
        // either blank kills the data enable
        next_cycle;
        hblank <= 1'b1;
        next_cycle;
        expect_now("video_hblank", sel_de, 32'd0);
        hblank <= 1'b0;
        vblank <= 1'b1;
        next_cycle;
        expect_now("video_vblank", sel_de, 32'd0);
        vblank <= 1'b0;

        sync_edge(1'b1, 1'b0, "hsync_pulse");
        sync_edge(1'b0, 1'b1, "vsync_pulse");
        sync_edge(1'b1, 1'b1, "both_sync_pulse");

        // let the last comparison land
        next_cycle;
        @(negedge clk_74a);
        if (n_checks > 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("no comparisons were made");
            $display("Test failed");
            $fatal(1, "empty run");
        end
    end

endmodule

//--- vlog.f
common/bridge_pkg.sv
common/video_pkg.sv
logic/bridge_regs.sv
loader/rom_loader.sv
loader/rom_store.sv
logic/input_sync.sv
logic/video_out.sv
logic/core_top.sv
sim/tb_clock.sv
sim/tb_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_core
FILELIST  = vlog.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
